// ==== verilog/scope_consts.svh ====
`ifndef SCOPE_CONSTS_SVH
`define SCOPE_CONSTS_SVH

// ADC code width
`define SCOPE_SAMPLE_W 12

// Samples per captured frame, and the index that spans them
`define SCOPE_FRAME_DEPTH 512
`define SCOPE_INDEX_W 9

// Zero-volt code of the ADC
`define SCOPE_MIDSCALE 2048

// Re-arm margin below the trigger threshold, in codes
`define SCOPE_HYSTERESIS 64

// Credits the consumer grants after reset
`define SCOPE_CREDITS 4

// Decimation ratio width
`define SCOPE_DECIM_W 12

`endif

// ==== verilog/scope_pkg.sv ====
`default_nettype none

`include "scope_consts.svh"

package scope_pkg;

    ////////////////////////////////////////
    // Scalar types
    ////////////////////////////////////////

    // Raw unsigned ADC code
    typedef logic [`SCOPE_SAMPLE_W-1:0] adc_sample_t;
    // Trigger level relative to mid-scale
    typedef logic signed [`SCOPE_SAMPLE_W-1:0] trig_offset_t;
    // Ratio minus one, so 0 keeps every sample
    typedef logic [`SCOPE_DECIM_W-1:0] decim_t;
    // Sample position within a frame
    typedef logic [`SCOPE_INDEX_W-1:0] frame_index_t;
    // Wide enough to hold the full initial credit grant
    typedef logic [$clog2(`SCOPE_CREDITS+1)-1:0] credit_t;

    ////////////////////////////////////////
    // Downstream stream beat
    ////////////////////////////////////////

    typedef struct packed {
        logic         valid;
        logic         last;
        frame_index_t index;
        adc_sample_t  data;
    } stream_beat_t;

    // Trigger FSM
    typedef enum logic [1:0] {TRIG_WAIT_LOW, TRIG_ARMED, TRIG_HOLD} trig_state_t;

    // Capture buffer FSM
    typedef enum logic [1:0] {CAP_IDLE, CAP_FILL, CAP_FULL} cap_state_t;

endpackage

`default_nettype wire

// ==== verilog/sample_decimator.sv ====
`timescale 1ns/1ps
`default_nettype none

module sample_decimator import scope_pkg::*; (
    input  wire logic        clk,
    input  wire logic        rst,
    input  wire adc_sample_t adc_data,
    input  wire decim_t      decim,
    output logic             tick,
    output adc_sample_t      tick_data
);

    ////////////////////////////////////////
    // Cycle counter
    ////////////////////////////////////////

    // Counts down to zero, tick on zero
    decim_t cnt;

    // Ratio only sampled on wrap, so a new
    // setting never cuts a period short
    always_ff @(posedge clk) begin
        if (rst) begin
            cnt  <= '0;
            tick <= 1'b0;
        end else begin
            if (cnt == '0) begin
                cnt  <= decim;
                tick <= 1'b1;
            end else begin
                cnt  <= cnt - 1'b1;
                tick <= 1'b0;
            end
        end
    end

    ////////////////////////////////////////
    // Sample register
    ////////////////////////////////////////

    // Capture the code alongside the tick
    // Held between ticks for slow ratios
    always_ff @(posedge clk) begin
        if (cnt == '0) begin
            tick_data <= adc_data;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/trigger_detector.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "scope_consts.svh"

module trigger_detector import scope_pkg::*; (
    input  wire logic         clk,
    input  wire logic         rst,
    input  wire logic         tick,
    input  wire adc_sample_t  tick_data,
    input  wire trig_offset_t trig_offset,
    input  wire logic         busy,
    output logic              fire
);

    ////////////////////////////////////////
    // Trigger levels
    ////////////////////////////////////////

    // Two extra bits so offset and margin can
    // push a level past either end of the code range
    localparam int LVL_W = `SCOPE_SAMPLE_W + 2;

    typedef logic signed [LVL_W-1:0] level_t;

    localparam level_t MID_LVL  = level_t'(`SCOPE_MIDSCALE);
    localparam level_t HYST_LVL = level_t'(`SCOPE_HYSTERESIS);

    level_t threshold;
    level_t rearm_level;
    level_t sample_lvl;

    // Sign-extend the offset onto mid-scale
    assign threshold   = MID_LVL + {{2{trig_offset[`SCOPE_SAMPLE_W-1]}}, trig_offset};
    assign rearm_level = threshold - HYST_LVL;
    // ADC codes are unsigned, so zero-extend
    assign sample_lvl  = {2'b00, tick_data};

    // Per-tick level decisions
    logic cross_hit;
    logic low_hit;

    assign cross_hit = tick && !busy && (sample_lvl >= threshold);
    assign low_hit   = tick && !busy && (sample_lvl < rearm_level);

    ////////////////////////////////////////
    // Arm / fire FSM
    ////////////////////////////////////////

    trig_state_t state;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= TRIG_WAIT_LOW;
            fire  <= 1'b0;
        end else begin
            // Single-cycle pulse
            fire <= 1'b0;
            case (state)
                // Need a clear dip below the re-arm level first
                TRIG_WAIT_LOW: begin
                    if (low_hit) begin
                        state <= TRIG_ARMED;
                    end
                end
                // First tick at or above threshold fires
                TRIG_ARMED: begin
                    if (cross_hit) begin
                        fire  <= 1'b1;
                        state <= TRIG_HOLD;
                    end
                end
                // busy rises one cycle after fire, so the
                // fire cycle itself must not count as idle
                TRIG_HOLD: begin
                    if (!busy && !fire) begin
                        state <= TRIG_WAIT_LOW;
                    end
                end
                default: begin
                    state <= TRIG_WAIT_LOW;
                end
            endcase
        end
    end

    ////////////////////////////////////////
    // Checks
    ////////////////////////////////////////

    // Buffer owns the frame while busy, no trigger may land on it
    a_no_fire_when_busy: assert property (
        @(posedge clk) disable iff (rst)
        fire |-> !busy
    );

endmodule

`default_nettype wire

// ==== verilog/capture_buffer.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "scope_consts.svh"

module capture_buffer import scope_pkg::*; (
    input  wire logic         clk,
    input  wire logic         rst,
    input  wire logic         tick,
    input  wire adc_sample_t  tick_data,
    input  wire logic         fire,
    input  wire logic         frame_release,
    input  wire frame_index_t rd_addr,
    output adc_sample_t       rd_data,
    output logic              busy,
    output logic              full
);

    localparam frame_index_t LAST_IDX = frame_index_t'(`SCOPE_FRAME_DEPTH - 1);

    ////////////////////////////////////////
    // Tick alignment
    ////////////////////////////////////////

    // fire trails the qualifying tick by one cycle
    // Delay the stream to match so word 0 is that tick
    logic        tick_d;
    adc_sample_t data_d;

    always_ff @(posedge clk) begin
        if (rst) begin
            tick_d <= 1'b0;
        end else begin
            tick_d <= tick;
        end
    end

    always_ff @(posedge clk) begin
        data_d <= tick_data;
    end

    ////////////////////////////////////////
    // Fill control
    ////////////////////////////////////////

    cap_state_t   state;
    frame_index_t wr_idx;
    logic         wr_en;

    // Trigger sample, then every delayed tick during fill
    assign wr_en = ((state == CAP_IDLE) && fire) || ((state == CAP_FILL) && tick_d);

    always_ff @(posedge clk) begin
        if (rst) begin
            state  <= CAP_IDLE;
            wr_idx <= '0;
        end else begin
            // Index wraps back to 0 after the last word
            if (wr_en) begin
                wr_idx <= wr_idx + 1'b1;
            end
            case (state)
                CAP_IDLE: begin
                    if (fire) begin
                        state <= CAP_FILL;
                    end
                end
                CAP_FILL: begin
                    if (tick_d && (wr_idx == LAST_IDX)) begin
                        state <= CAP_FULL;
                    end
                end
                // Held until the streamer is done
                CAP_FULL: begin
                    if (frame_release) begin
                        state <= CAP_IDLE;
                    end
                end
                default: begin
                    state <= CAP_IDLE;
                end
            endcase
        end
    end

    assign busy = (state != CAP_IDLE);
    assign full = (state == CAP_FULL);

    ////////////////////////////////////////
    // Sample memory
    ////////////////////////////////////////

    adc_sample_t mem [0:`SCOPE_FRAME_DEPTH-1];

    // Block RAM style, registered read
    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_idx] <= data_d;
        end
        rd_data <= mem[rd_addr];
    end

    ////////////////////////////////////////
    // Checks
    ////////////////////////////////////////

    // Detector must be held off for the whole capture
    a_fire_only_idle: assert property (
        @(posedge clk) disable iff (rst)
        fire |-> (state == CAP_IDLE)
    );

    // Streamer hands back only a complete frame
    a_release_only_full: assert property (
        @(posedge clk) disable iff (rst)
        frame_release |-> (state == CAP_FULL)
    );

endmodule

`default_nettype wire

// ==== verilog/frame_streamer.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "scope_consts.svh"

module frame_streamer import scope_pkg::*; (
    input  wire logic        clk,
    input  wire logic        rst,
    input  wire logic        full,
    input  wire adc_sample_t rd_data,
    input  wire logic        credit_return,
    output frame_index_t     rd_addr,
    output logic             frame_release,
    output stream_beat_t     beat
);

    localparam frame_index_t LAST_IDX = frame_index_t'(`SCOPE_FRAME_DEPTH - 1);
    localparam credit_t      MAX_CRED = credit_t'(`SCOPE_CREDITS);

    ////////////////////////////////////////
    // Read issue
    ////////////////////////////////////////

    credit_t      credits;
    frame_index_t rd_idx;
    // All 512 reads of this frame are out
    logic         issued_all;
    logic         issue;

    assign issue   = full && (credits != '0) && !issued_all;
    assign rd_addr = rd_idx;

    always_ff @(posedge clk) begin
        if (rst) begin
            credits    <= MAX_CRED;
            rd_idx     <= '0;
            issued_all <= 1'b0;
        end else begin
            // Spend and return can coincide
            credits <= credits - credit_t'(issue) + credit_t'(credit_return);
            if (issue) begin
                rd_idx <= rd_idx + 1'b1;
                if (rd_idx == LAST_IDX) begin
                    issued_all <= 1'b1;
                end
            end
            // Ready for the next frame
            if (frame_release) begin
                issued_all <= 1'b0;
            end
        end
    end

    ////////////////////////////////////////
    // Beat output
    ////////////////////////////////////////

    // RAM data lands one cycle after issue
    logic         beat_valid;
    frame_index_t beat_idx;

    always_ff @(posedge clk) begin
        if (rst) begin
            beat_valid    <= 1'b0;
            frame_release <= 1'b0;
        end else begin
            beat_valid    <= issue;
            frame_release <= beat.valid && beat.last;
        end
    end

    always_ff @(posedge clk) begin
        if (issue) begin
            beat_idx <= rd_idx;
        end
    end

    assign beat.valid = beat_valid;
    assign beat.last  = beat_valid && (beat_idx == LAST_IDX);
    assign beat.index = beat_idx;
    assign beat.data  = rd_data;

    ////////////////////////////////////////
    // Checks
    ////////////////////////////////////////

    // Consumer may not hand back more than it got
    a_credit_bound: assert property (
        @(posedge clk) disable iff (rst)
        credits <= MAX_CRED
    );

endmodule

`default_nettype wire

// ==== verilog/scope_capture_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module scope_capture_top import scope_pkg::*; (
    input  wire logic         clk,
    input  wire logic         rst,
    input  wire adc_sample_t  adc_data,
    input  wire decim_t       decim,
    input  wire trig_offset_t trig_offset,
    input  wire logic         credit_return,
    output stream_beat_t      beat
);

    ////////////////////////////////////////
    // Internal nets
    ////////////////////////////////////////

    // Decimated stream
    logic         tick;
    adc_sample_t  tick_data;
    // Trigger / buffer handshake
    logic         fire;
    logic         busy;
    logic         full;
    logic         frame_release;
    // Buffer read port
    frame_index_t rd_addr;
    adc_sample_t  rd_data;

    ////////////////////////////////////////
    // Acquisition chain
    ////////////////////////////////////////

    sample_decimator u_decim (
        .clk       (clk),
        .rst       (rst),
        .adc_data  (adc_data),
        .decim     (decim),
        .tick      (tick),
        .tick_data (tick_data)
    );

    trigger_detector u_trig (
        .clk         (clk),
        .rst         (rst),
        .tick        (tick),
        .tick_data   (tick_data),
        .trig_offset (trig_offset),
        .busy        (busy),
        .fire        (fire)
    );

    capture_buffer u_buf (
        .clk           (clk),
        .rst           (rst),
        .tick          (tick),
        .tick_data     (tick_data),
        .fire          (fire),
        .frame_release (frame_release),
        .rd_addr       (rd_addr),
        .rd_data       (rd_data),
        .busy          (busy),
        .full          (full)
    );

    // Credit-paced readout
    frame_streamer u_stream (
        .clk           (clk),
        .rst           (rst),
        .full          (full),
        .rd_data       (rd_data),
        .credit_return (credit_return),
        .rd_addr       (rd_addr),
        .frame_release (frame_release),
        .beat          (beat)
    );

endmodule

`default_nettype wire

// ==== tests/scope_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "scope_consts.svh"

module scope_tb import scope_pkg::*; ();

    ////////////////////////////////////////
    // Test setup
    ////////////////////////////////////////

    localparam int TRIG_OFS    = 256;
    localparam int THRESHOLD   = `SCOPE_MIDSCALE + TRIG_OFS;
    localparam int REARM_LEVEL = THRESHOLD - `SCOPE_HYSTERESIS;
    // Held well above threshold in the hold-off phase
    localparam int HOLD_CODE   = 3000;
    localparam int HOLD_CYCLES = 2000;
    localparam int LONG_STALL  = 100;
    // Ramp wrap twice, slowest capture, slow credit drip
    localparam int FRAME_BUDGET    = 2 * 4096 + 8 * `SCOPE_FRAME_DEPTH + 40 * `SCOPE_FRAME_DEPTH;
    localparam int WATCHDOG_CYCLES = 3 * FRAME_BUDGET + HOLD_CYCLES + 64;
    localparam frame_index_t LAST_IDX = frame_index_t'(`SCOPE_FRAME_DEPTH - 1);

    logic         clk;
    logic         rst;
    adc_sample_t  adc_data = '0;
    decim_t       decim;
    trig_offset_t trig_offset;
    logic         credit_return = 1'b0;
    stream_beat_t beat;

    scope_capture_top UUT (
        .clk           (clk),
        .rst           (rst),
        .adc_data      (adc_data),
        .decim         (decim),
        .trig_offset   (trig_offset),
        .credit_return (credit_return),
        .beat          (beat)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    ////////////////////////////////////////
    // Failure reporting
    ////////////////////////////////////////

    task automatic stop_run;
        $display("Something failed");
        $fatal(1, "stopped at first error");
    endtask

    task automatic report_value(input string sig, input int expected, input int actual);
        $display("[ERROR] %0t ns: %s expected %0d, got %0d", $time, sig, expected, actual);
        stop_run();
    endtask

    task automatic report_fault(input string what);
        $display("%s", what);
        stop_run();
    endtask

    ////////////////////////////////////////
    // Sawtooth source
    ////////////////////////////////////////

    adc_sample_t ramp = '0;
    logic        hold_high = 1'b0;

    // One code per clock, 12-bit wrap
    always @(negedge clk) begin
        ramp     <= ramp + 1'b1;
        adc_data <= hold_high ? adc_sample_t'(HOLD_CODE) : ramp + 1'b1;
    end

    ////////////////////////////////////////
    // Reference model and beat monitor
    ////////////////////////////////////////

    decim_t       mcnt;
    logic         m_armed;
    logic         m_busy;
    logic         release_seen;
    logic         fire_pending;
    int           m_fires;
    adc_sample_t  exp_first;
    int           frame_step;
    frame_index_t exp_idx;
    adc_sample_t  prev_data;
    int           beats_rx;
    int           frames_done;
    adc_sample_t  next_data;
    adc_sample_t  tick_before;

    // Expected successor and predecessor within the decimated ramp
    assign next_data   = prev_data + adc_sample_t'(frame_step);
    assign tick_before = beat.data - adc_sample_t'(frame_step);

    always @(posedge clk) begin
        if (rst) begin
            mcnt         <= '0;
            m_armed      <= 1'b0;
            m_busy       <= 1'b0;
            release_seen <= 1'b0;
            fire_pending <= 1'b0;
            m_fires      <= 0;
            exp_first    <= '0;
            frame_step   <= 1;
            exp_idx      <= '0;
            prev_data    <= '0;
            beats_rx     <= 0;
            frames_done  <= 0;
        end else begin
            // Keep one code out of every decim+1
            if (mcnt == '0) begin
                mcnt <= decim;
                if (!m_busy && m_armed && (adc_data >= THRESHOLD)) begin
                    m_armed      <= 1'b0;
                    m_busy       <= 1'b1;
                    fire_pending <= 1'b1;
                    exp_first    <= adc_data;
                    frame_step   <= int'(decim) + 1;
                    m_fires      <= m_fires + 1;
                end else if (!m_busy && (adc_data < REARM_LEVEL)) begin
                    m_armed <= 1'b1;
                end
            end else begin
                mcnt <= mcnt - 1'b1;
            end
            // Trigger ignores ticks until the buffer is idle again
            if (release_seen) begin
                m_busy       <= 1'b0;
                release_seen <= 1'b0;
            end
            if (beat.valid) begin
                exp_idx   <= exp_idx + 1'b1;
                prev_data <= beat.data;
                beats_rx  <= beats_rx + 1;
                if (beat.index == '0) begin
                    fire_pending <= 1'b0;
                end
                if (beat.last) begin
                    frames_done  <= frames_done + 1;
                    release_seen <= 1'b1;
                end
            end
        end
    end

    ////////////////////////////////////////
    // Consumer credit return
    ////////////////////////////////////////

    int          seed = 32'hb6b50562;
    int          credits_back = 0;
    int          gap = 0;
    logic [31:0] rnd;

    // Short random gaps, now and then a long stall
    always @(negedge clk) begin
        credit_return <= 1'b0;
        if (rst) begin
            gap = 0;
        end else if (gap > 0) begin
            gap = gap - 1;
        end else if (beats_rx > credits_back) begin
            credit_return <= 1'b1;
            credits_back = credits_back + 1;
            rnd = $random(seed);
            gap = (rnd[5:0] == 6'd0) ? LONG_STALL : int'(rnd[8:6]);
        end
    end

    ////////////////////////////////////////
    // Checks
    ////////////////////////////////////////

    a_quiet_before_trigger: assert property (@(posedge clk) disable iff (rst)
        (m_fires == 0) |-> !beat.valid)
        else report_value("beat.valid", 0, $sampled(beat.valid));

    // A frame needs an armed crossing in the model
    a_frame_has_trigger: assert property (@(posedge clk) disable iff (rst)
        (beat.valid && beat.index == '0) |-> fire_pending)
        else report_fault("frame started without an armed threshold crossing");

    a_first_sample: assert property (@(posedge clk) disable iff (rst)
        (beat.valid && beat.index == '0) |-> (beat.data == exp_first))
        else report_value("beat.data", $sampled(exp_first), $sampled(beat.data));

    a_first_above: assert property (@(posedge clk) disable iff (rst)
        (beat.valid && beat.index == '0) |-> (beat.data >= THRESHOLD))
        else report_fault("first sample of frame is below the threshold");

    a_prior_below: assert property (@(posedge clk) disable iff (rst)
        (beat.valid && beat.index == '0) |-> (tick_before < THRESHOLD))
        else report_fault("tick before the trigger was already above the threshold");

    a_step: assert property (@(posedge clk) disable iff (rst)
        (beat.valid && exp_idx != '0) |-> (beat.data == next_data))
        else report_value("beat.data", $sampled(next_data), $sampled(beat.data));

    a_index: assert property (@(posedge clk) disable iff (rst)
        beat.valid |-> (beat.index == exp_idx))
        else report_value("beat.index", $sampled(exp_idx), $sampled(beat.index));

    a_last: assert property (@(posedge clk) disable iff (rst)
        beat.valid |-> (beat.last == (exp_idx == LAST_IDX)))
        else report_value("beat.last", $sampled(exp_idx == LAST_IDX), $sampled(beat.last));

    a_outstanding: assert property (@(posedge clk) disable iff (rst)
        (beats_rx - credits_back) <= `SCOPE_CREDITS)
        else report_fault("more beats outstanding than the consumer granted credits");

    ////////////////////////////////////////
    // Sequence
    ////////////////////////////////////////

    task automatic wait_for_frames(input int count);
        while (frames_done < count) begin
            @(posedge clk);
        end
    endtask

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        report_fault($sformatf("Timeout: only %0d of 3 frames done after %0d cycles",
                               frames_done, WATCHDOG_CYCLES));
    end

    initial begin
        rst         = 1'b1;
        decim       = '0;
        trig_offset = trig_offset_t'(TRIG_OFS);
        repeat (16) @(posedge clk);
        @(negedge clk);
        rst <= 1'b0;

        // Full-rate frame
        // Capture is complete once the first beat is out
        while (beats_rx == 0) begin
            @(posedge clk);
        end
        // Park the input above threshold before the buffer goes idle
        @(negedge clk);
        hold_high <= 1'b1;
        wait_for_frames(1);
        // Detector back from hold with no dip, so no retrigger
        @(negedge clk);
        decim <= decim_t'(3);
        repeat (HOLD_CYCLES) @(negedge clk);
        hold_high <= 1'b0;

        wait_for_frames(2);
        @(negedge clk);
        decim <= decim_t'(7);
        wait_for_frames(3);

        repeat (8) @(posedge clk);
        $display("Everything OK");
        $finish;
    end

endmodule

`default_nettype wire

// ==== filelist.f ====
+incdir+verilog
verilog/scope_pkg.sv
verilog/sample_decimator.sv
verilog/trigger_detector.sv
verilog/capture_buffer.sv
verilog/frame_streamer.sv
verilog/scope_capture_top.sv
tests/scope_tb.sv
